// ==== logic/mips_pkg.sv ====
// ==============================
// MIPS decode widths, opcodes and
// ALU operation class encoding
// ==============================

package mips_pkg;

	// ==============================
	// word and field widths
	// ==============================

	// data and address word
	localparam int DATA_W = 32;

	// register number field
	localparam int REG_AW = 5;

	// architectural register count
	localparam int NUM_REGS = 32;

	// opcode field, instr[31:26]
	localparam int OP_W = 6;

	// immediate field, instr[15:0]
	localparam int IMM_W = 16;

	// ==============================
	// supported opcodes
	// ==============================

	// R-type uses funct for the real operation
	localparam logic [OP_W-1:0] OP_RTYPE = 6'd0;

	// memory access
	localparam logic [OP_W-1:0] OP_LW = 6'd35;
	localparam logic [OP_W-1:0] OP_SW = 6'd43;

	// conditional branch
	localparam logic [OP_W-1:0] OP_BEQ = 6'd4;

	// add immediate
	localparam logic [OP_W-1:0] OP_ADDI = 6'd8;

	// ==============================
	// ALU operation class
	// ==============================

	localparam int ALUOP_W = 2;

	// add for address calc, sub for compare, funct for R-type
	typedef enum logic [ALUOP_W-1:0] {
		ALUOP_ADD   = 2'd0,
		ALUOP_SUB   = 2'd1,
		ALUOP_FUNCT = 2'd2
	} aluop_t;

endpackage

// ==== logic/ctrl_if.sv ====
// ==============================
// decoded control bundle from
// control decoder to decode register
// ==============================

`timescale 1ns/100ps

interface ctrl_if;
	import mips_pkg::*;

	// execute stage controls
	logic regdst;
	logic alusrc;
	aluop_t aluop;

	// memory stage controls
	logic memread;
	logic memwrite;
	logic branch;

	// write-back stage controls
	logic memtoreg;
	logic regwrite;

	modport src (
		output regdst, alusrc, aluop, memread, memwrite, branch, memtoreg, regwrite
	);

	modport dst (
		input regdst, alusrc, aluop, memread, memwrite, branch, memtoreg, regwrite
	);

endinterface

// ==== logic/regrd_if.sv ====
// ==============================
// register bank read ports
// ==============================

`timescale 1ns/100ps

interface regrd_if;
	import mips_pkg::*;

	// source register numbers
	logic [REG_AW-1:0] rs_addr;
	logic [REG_AW-1:0] rt_addr;

	// values read back, same cycle
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] rt_data;

	// decode side drives the addresses
	modport user (
		output rs_addr,
		output rt_addr,
		input  rs_data,
		input  rt_data
	);

	// bank answers with the stored words
	modport bank (
		input  rs_addr,
		input  rt_addr,
		output rs_data,
		output rt_data
	);

endinterface

// ==== logic/main_control.sv ====
// ==============================
// main control decoder
// ==============================

`timescale 1ns/100ps

module main_control (
	input  logic [mips_pkg::OP_W-1:0] i_opcode,
	ctrl_if.src                        o_ctrl
);

	import mips_pkg::*;

	// ==============================
	// opcode to control table
	// ==============================

	always_comb begin
		// everything off unless the opcode is known
		o_ctrl.regdst   = 1'b0;
		o_ctrl.alusrc   = 1'b0;
		o_ctrl.memtoreg = 1'b0;
		o_ctrl.regwrite = 1'b0;
		o_ctrl.memread  = 1'b0;
		o_ctrl.memwrite = 1'b0;
		o_ctrl.branch   = 1'b0;
		o_ctrl.aluop    = ALUOP_ADD;

		case (i_opcode)
			OP_RTYPE: begin
				// destination is rd and the ALU op comes from funct
				o_ctrl.regdst   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_FUNCT;
			end

			OP_LW: begin
				// address is base + offset and the load result goes to rt
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.memtoreg = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.memread  = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end

			OP_SW: begin
				// address is base + offset and rt goes to memory
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.memwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end

			OP_BEQ: begin
				// compare rs and rt by subtraction
				o_ctrl.branch = 1'b1;
				o_ctrl.aluop  = ALUOP_SUB;
			end

			OP_ADDI: begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
		endcase
	end

endmodule

// ==== logic/register_bank.sv ====
// ==============================
// 32 x 32 register file
// two async reads, one sync write
// ==============================

`timescale 1ns/100ps

module register_bank (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_wr_en,
	input  logic [mips_pkg::REG_AW-1:0] i_wr_addr,
	input  logic [mips_pkg::DATA_W-1:0] i_wr_data,
	regrd_if.bank                       rd
);

	import mips_pkg::*;

	// register storage
	logic [DATA_W-1:0] regs [NUM_REGS];

	// write to $zero is dropped
	logic wr_hit;

	assign wr_hit = i_wr_en && (i_wr_addr != '0);

	// ==============================
	// write port
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// ==============================
	// read ports
	// ==============================

	// no bypass, a same-cycle write shows up only after the edge
	always_comb begin
		if (rd.rs_addr == '0) begin
			rd.rs_data = '0;
		end else begin
			rd.rs_data = regs[rd.rs_addr];
		end
	end

	always_comb begin
		if (rd.rt_addr == '0) begin
			rd.rt_data = '0;
		end else begin
			rd.rt_data = regs[rd.rt_addr];
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
// ==============================
// field split, sign extension and
// ID/EX pipeline register
// ==============================

`timescale 1ns/100ps

module decode_stage (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic [mips_pkg::DATA_W-1:0] i_instr,
	input  logic [mips_pkg::DATA_W-1:0] i_next_pc,
	ctrl_if.dst                         ctrl,
	regrd_if.user                       rd,

	// execute controls
	output logic                        o_ex_regdst,
	output logic                        o_ex_alusrc,
	output mips_pkg::aluop_t            o_ex_aluop,
	// memory controls
	output logic                        o_mem_branch,
	output logic                        o_mem_memread,
	output logic                        o_mem_memwrite,
	// write-back controls
	output logic                        o_wb_memtoreg,
	output logic                        o_wb_regwrite,

	output logic [mips_pkg::DATA_W-1:0] o_next_pc,
	output logic [mips_pkg::DATA_W-1:0] o_rs_data,
	output logic [mips_pkg::DATA_W-1:0] o_rt_data,
	output logic [mips_pkg::DATA_W-1:0] o_imm_ext,
	output logic [mips_pkg::REG_AW-1:0] o_rt_addr,
	output logic [mips_pkg::REG_AW-1:0] o_rd_addr
);

	import mips_pkg::*;

	// ==============================
	// instruction fields
	// ==============================

	logic [REG_AW-1:0] rt_field;
	logic [REG_AW-1:0] rd_field;
	logic [IMM_W-1:0]  imm_field;
	logic [DATA_W-1:0] imm_ext;

	assign rt_field  = i_instr[20:16];
	assign rd_field  = i_instr[15:11];
	assign imm_field = i_instr[IMM_W-1:0];

	// register bank read addresses
	assign rd.rs_addr = i_instr[25:21];
	assign rd.rt_addr = rt_field;

	// replicate bit 15 into the upper half
	assign imm_ext = {{(DATA_W-IMM_W){imm_field[IMM_W-1]}}, imm_field};

	// ==============================
	// ID/EX register
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ex_regdst    <= 1'b0;
			o_ex_alusrc    <= 1'b0;
			o_ex_aluop     <= ALUOP_ADD;
			o_mem_branch   <= 1'b0;
			o_mem_memread  <= 1'b0;
			o_mem_memwrite <= 1'b0;
			o_wb_memtoreg  <= 1'b0;
			o_wb_regwrite  <= 1'b0;
			o_next_pc      <= '0;
			o_rs_data      <= '0;
			o_rt_data      <= '0;
			o_imm_ext      <= '0;
			o_rt_addr      <= '0;
			o_rd_addr      <= '0;
		end else begin
			// control bundle
			o_ex_regdst    <= ctrl.regdst;
			o_ex_alusrc    <= ctrl.alusrc;
			o_ex_aluop     <= ctrl.aluop;
			o_mem_branch   <= ctrl.branch;
			o_mem_memread  <= ctrl.memread;
			o_mem_memwrite <= ctrl.memwrite;
			o_wb_memtoreg  <= ctrl.memtoreg;
			o_wb_regwrite  <= ctrl.regwrite;
			// datapath
			o_next_pc      <= i_next_pc;
			o_rs_data      <= rd.rs_data;
			o_rt_data      <= rd.rt_data;
			o_imm_ext      <= imm_ext;
			// both destination candidates, regdst picks later
			o_rt_addr      <= rt_field;
			o_rd_addr      <= rd_field;
		end
	end

endmodule

// ==== logic/decode_top.sv ====
// ==============================
// decode stage top level
// ==============================

`timescale 1ns/100ps

module decode_top (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic [mips_pkg::DATA_W-1:0] i_instr,
	input  logic [mips_pkg::DATA_W-1:0] i_next_pc,
	input  logic                        i_wb_regwrite,
	input  logic [mips_pkg::REG_AW-1:0] i_wb_addr,
	input  logic [mips_pkg::DATA_W-1:0] i_wb_data,

	output logic                        o_ex_regdst,
	output logic                        o_ex_alusrc,
	output mips_pkg::aluop_t            o_ex_aluop,
	output logic                        o_mem_branch,
	output logic                        o_mem_memread,
	output logic                        o_mem_memwrite,
	output logic                        o_wb_memtoreg,
	output logic                        o_wb_regwrite,
	output logic [mips_pkg::DATA_W-1:0] o_next_pc,
	output logic [mips_pkg::DATA_W-1:0] o_rs_data,
	output logic [mips_pkg::DATA_W-1:0] o_rt_data,
	output logic [mips_pkg::DATA_W-1:0] o_imm_ext,
	output logic [mips_pkg::REG_AW-1:0] o_rt_addr,
	output logic [mips_pkg::REG_AW-1:0] o_rd_addr
);

	import mips_pkg::*;

	// opcode is instr[31:26]
	logic [OP_W-1:0] opcode;

	assign opcode = i_instr[DATA_W-1 -: OP_W];

	ctrl_if  u_ctrl_if ();
	regrd_if u_rd_if ();

	main_control u_control (
		.i_opcode (opcode),
		.o_ctrl   (u_ctrl_if.src)
	);

	register_bank u_regs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (i_wb_regwrite),
		.i_wr_addr (i_wb_addr),
		.i_wr_data (i_wb_data),
		.rd        (u_rd_if.bank)
	);

	decode_stage u_stage (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_instr        (i_instr),
		.i_next_pc      (i_next_pc),
		.ctrl           (u_ctrl_if.dst),
		.rd             (u_rd_if.user),
		.o_ex_regdst    (o_ex_regdst),
		.o_ex_alusrc    (o_ex_alusrc),
		.o_ex_aluop     (o_ex_aluop),
		.o_mem_branch   (o_mem_branch),
		.o_mem_memread  (o_mem_memread),
		.o_mem_memwrite (o_mem_memwrite),
		.o_wb_memtoreg  (o_wb_memtoreg),
		.o_wb_regwrite  (o_wb_regwrite),
		.o_next_pc      (o_next_pc),
		.o_rs_data      (o_rs_data),
		.o_rt_data      (o_rt_data),
		.o_imm_ext      (o_imm_ext),
		.o_rt_addr      (o_rt_addr),
		.o_rd_addr      (o_rd_addr)
	);

endmodule

// ==== verif/decode_model.svh ====
// ==============================
// reference model, control table,
// register mirror, expected outputs
// ==============================

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// register file as the testbench sees it
logic [DATA_W-1:0] reg_mirror [NUM_REGS];

// expected decode outputs for the next edge
// ctrl bits: regdst alusrc aluop[1:0] branch memread memwrite memtoreg regwrite
logic [8:0]        exp_ctrl;
logic [DATA_W-1:0] exp_next_pc;
logic [DATA_W-1:0] exp_rs_data;
logic [DATA_W-1:0] exp_rt_data;
logic [DATA_W-1:0] exp_imm_ext;
logic [REG_AW-1:0] exp_rt_addr;
logic [REG_AW-1:0] exp_rd_addr;

function automatic logic [8:0] ctrl_table(input logic [OP_W-1:0] op);
	case (op)
		OP_RTYPE: return 9'b1_0_10_0_0_0_0_1;
		OP_LW:    return 9'b0_1_00_0_1_0_1_1;
		OP_SW:    return 9'b0_1_00_0_0_1_0_0;
		OP_BEQ:   return 9'b0_0_01_1_0_0_0_0;
		OP_ADDI:  return 9'b0_1_00_0_0_0_0_1;
		default:  return 9'b0;
	endcase
endfunction

// register values are the ones before the edge
task automatic predict(input logic [DATA_W-1:0] instr, input logic [DATA_W-1:0] npc);
	exp_ctrl    = ctrl_table(instr[31:26]);
	exp_next_pc = npc;
	exp_rs_data = reg_mirror[instr[25:21]];
	exp_rt_data = reg_mirror[instr[20:16]];
	exp_imm_ext = {{16{instr[15]}}, instr[15:0]};
	exp_rt_addr = instr[20:16];
	exp_rd_addr = instr[15:11];
endtask

task automatic mirror_write(input logic we, input logic [REG_AW-1:0] addr,
		input logic [DATA_W-1:0] data);
	if (we && addr != '0) begin
		reg_mirror[addr] = data;
	end
endtask

// reset clears the bank and every decode output
task automatic model_reset();
	for (int i = 0; i < NUM_REGS; i++) begin
		reg_mirror[i] = '0;
	end
	exp_ctrl    = '0;
	exp_next_pc = '0;
	exp_rs_data = '0;
	exp_rt_data = '0;
	exp_imm_ext = '0;
	exp_rt_addr = '0;
	exp_rd_addr = '0;
endtask

`endif

// ==== verif/tb_decode_top.sv ====
// ==============================
// testbench for the decode stage
// ==============================

`timescale 1ns/100ps

module tb_decode_top;

	import mips_pkg::*;

	logic              i_clk;
	logic              i_rst_n;
	logic [DATA_W-1:0] i_instr;
	logic [DATA_W-1:0] i_next_pc;
	logic              i_wb_regwrite;
	logic [REG_AW-1:0] i_wb_addr;
	logic [DATA_W-1:0] i_wb_data;
	logic              o_ex_regdst;
	logic              o_ex_alusrc;
	aluop_t            o_ex_aluop;
	logic              o_mem_branch;
	logic              o_mem_memread;
	logic              o_mem_memwrite;
	logic              o_wb_memtoreg;
	logic              o_wb_regwrite;
	logic [DATA_W-1:0] o_next_pc;
	logic [DATA_W-1:0] o_rs_data;
	logic [DATA_W-1:0] o_rt_data;
	logic [DATA_W-1:0] o_imm_ext;
	logic [REG_AW-1:0] o_rt_addr;
	logic [REG_AW-1:0] o_rd_addr;

	integer      seed;
	int unsigned edge_cnt = 0;
	logic        timed_out = 1'b0;
	int          test_errs = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;

	`include "decode_model.svh"

	decode_top dut0 (.*);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		edge_cnt++;
	end

	// ==============================
	// helpers
	// ==============================

	function automatic logic [DATA_W-1:0] rand_word();
		return $random(seed);
	endfunction

	// mostly supported opcodes, some random ones
	function automatic logic [DATA_W-1:0] rand_instr();
		logic [DATA_W-1:0] r;
		logic [OP_W-1:0]   op;
		int                sel;
		r = $random(seed);
		sel = $unsigned($random(seed)) % 8;
		case (sel)
			0:       op = OP_RTYPE;
			1:       op = OP_LW;
			2:       op = OP_SW;
			3:       op = OP_BEQ;
			4:       op = OP_ADDI;
			default: op = r[31:26];
		endcase
		return {op, r[25:0]};
	endfunction

	// polls in 1 ns steps, so it returns 0.5 ns after an edge
	task automatic wait_edges(input int n, input string what);
		int unsigned target;
		int          guard;
		if (timed_out) return;
		target = edge_cnt + n;
		guard = 0;
		while (edge_cnt < target && guard < 4 * n + 8) begin
			#1;
			guard++;
		end
		if (edge_cnt < target) begin
			$display("timeout: clock stopped while waiting for %s", what);
			timed_out = 1'b1;
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		check_field("o_ex_regdst", 32'(exp_ctrl[8]), 32'(o_ex_regdst));
		check_field("o_ex_alusrc", 32'(exp_ctrl[7]), 32'(o_ex_alusrc));
		check_field("o_ex_aluop", 32'(exp_ctrl[6:5]), 32'(o_ex_aluop));
		check_field("o_mem_branch", 32'(exp_ctrl[4]), 32'(o_mem_branch));
		check_field("o_mem_memread", 32'(exp_ctrl[3]), 32'(o_mem_memread));
		check_field("o_mem_memwrite", 32'(exp_ctrl[2]), 32'(o_mem_memwrite));
		check_field("o_wb_memtoreg", 32'(exp_ctrl[1]), 32'(o_wb_memtoreg));
		check_field("o_wb_regwrite", 32'(exp_ctrl[0]), 32'(o_wb_regwrite));
		check_field("o_next_pc", exp_next_pc, o_next_pc);
		check_field("o_rs_data", exp_rs_data, o_rs_data);
		check_field("o_rt_data", exp_rt_data, o_rt_data);
		check_field("o_imm_ext", exp_imm_ext, o_imm_ext);
		check_field("o_rt_addr", 32'(exp_rt_addr), 32'(o_rt_addr));
		check_field("o_rd_addr", 32'(exp_rd_addr), 32'(o_rd_addr));
	endtask

	task automatic drive(input logic [DATA_W-1:0] instr, input logic [DATA_W-1:0] npc,
			input logic we, input logic [REG_AW-1:0] wa, input logic [DATA_W-1:0] wd);
		i_instr       = instr;
		i_next_pc     = npc;
		i_wb_regwrite = we;
		i_wb_addr     = wa;
		i_wb_data     = wd;
	endtask

	// one instruction in, outputs checked after the edge
	task automatic step(input logic [DATA_W-1:0] instr, input logic [DATA_W-1:0] npc,
			input logic we, input logic [REG_AW-1:0] wa, input logic [DATA_W-1:0] wd);
		if (timed_out) return;
		drive(instr, npc, we, wa, wd);
		predict(instr, npc);
		mirror_write(we, wa, wd);
		wait_edges(1, "decode cycle");
		if (!timed_out) check_outputs();
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0 && !timed_out) begin
			pass_cnt++;
			$display("test %s done, no mismatches", name);
		end else begin
			fail_cnt++;
			$display("test %s done, %0d mismatches", name, test_errs);
		end
		test_errs = 0;
	endtask

	// ==============================
	// tests
	// ==============================

	task automatic run_reset_test();
		logic [DATA_W-1:0] r;
		for (int i = 0; i < 16; i++) begin
			// inputs toggle, stage stays cleared
			r = rand_word();
			drive(rand_instr(), r, 1'b1, r[4:0], ~r);
			model_reset();
			wait_edges(1, "reset cycle");
			if (!timed_out) check_outputs();
		end
		i_rst_n = 1'b1;
		// unknown opcode with zero fields
		step(32'hfc00_0000, '0, 1'b0, '0, '0);
		for (int k = 0; k < NUM_REGS; k += 2) begin
			step({OP_RTYPE, 5'(k), 5'(k + 1), 16'h0}, rand_word(), 1'b0, '0, '0);
		end
		end_test("reset");
	endtask

	task automatic run_regs_test();
		logic [DATA_W-1:0] r;
		logic [DATA_W-1:0] instr;
		logic [REG_AW-1:0] wa;
		for (int i = 0; i < 32; i++) begin
			r = rand_word();
			wa = (r[4:0] == '0) ? 5'd1 : r[4:0];
			step(rand_instr(), rand_word(), 1'b1, wa, rand_word());
			// read back through rs or rt
			instr = rand_instr();
			if (r[5]) begin
				instr[25:21] = wa;
			end else begin
				instr[20:16] = wa;
			end
			step(instr, rand_word(), 1'b0, '0, '0);
			// write and read in one cycle gives the old word
			instr[25:21] = wa;
			instr[20:16] = wa;
			step(instr, rand_word(), 1'b1, wa, rand_word());
			step(instr, rand_word(), 1'b0, '0, '0);
			// $zero ignores writes
			step({OP_ADDI, 5'd0, 5'd0, r[31:16]}, rand_word(), 1'b1, '0, rand_word());
			step({OP_ADDI, 5'd0, 5'd0, r[15:0]}, rand_word(), 1'b0, '0, '0);
		end
		end_test("register write and read");
	endtask

	initial begin
		seed = 32'h98a3_9a31;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		drive('0, '0, 1'b0, '0, '0);
		model_reset();
		#0.5;
		run_reset_test();
		for (int i = 0; i < 200; i++) begin
			step(rand_instr(), rand_word(), 1'b0, '0, '0);
		end
		end_test("control decode");
		run_regs_test();
		for (int i = 0; i < 100; i++) begin
			step(rand_instr(), rand_word(), 1'b0, '0, '0);
		end
		end_test("field forwarding");
		for (int i = 0; i < 1000; i++) begin
			step(rand_instr(), rand_word(), rand_word() != '0, 5'(rand_word()), rand_word());
		end
		end_test("mixed random");
		$display("tests passed: %0d failed: %0d", pass_cnt, fail_cnt);
		if (!timed_out && fail_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verif
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/regrd_if.sv
logic/main_control.sv
logic/register_bank.sv
logic/decode_stage.sv
logic/decode_top.sv
verif/tb_decode_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_decode_top -f flist.f -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"
